/* source/vdpPkg.sv */
package vdpPkg;

	// Basic widths
	typedef logic [17:0] vramAddr_t;
	typedef logic [15:0] word_t;
	typedef logic signed [10:0] coord_t;

	// Y[7:0] then X[8:0], 512 x 256 frame buffer
	typedef logic [16:0] fbAddr_t;

	typedef struct packed {
		logic [9:0] x1;
		logic [8:0] y1;
		logic [9:0] x2;
		logic [8:0] y2;
	} clip_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t;

	typedef struct packed {
		fbAddr_t addr;
		word_t   data;
	} fbWrite_t;

	// One normal sprite job handed to the draw engine
	typedef struct packed {
		vramAddr_t  srcAddr;
		logic [8:0] width;
		logic [7:0] height;
		logic [2:0] colorMode;
		word_t      colorBank;
		logic       spd;
		logic       userClipEn;
		point_t     origin;
		clip_t      sysClip;
		clip_t      userClip;
	} spriteCmd_t;

	// Command table layout
	localparam int cmdWords = 16;
	localparam int cmdFetchWords = 12;
	localparam int ctrlOfs = 0;
	localparam int linkOfs = 1;
	localparam int pmodOfs = 2;
	localparam int colrOfs = 3;
	localparam int srcaOfs = 4;
	localparam int sizeOfs = 5;
	localparam int xaOfs = 6;
	localparam int yaOfs = 7;
	localparam int xcOfs = 10;
	localparam int ycOfs = 11;

	// Command codes, CTRL[3:0]
	localparam logic [3:0] cmdNormal = 4'h0;
	localparam logic [3:0] cmdUserClip = 4'h8;
	localparam logic [3:0] cmdSysClip = 4'h9;
	localparam logic [3:0] cmdLocal = 4'hA;

	// Colour modes, PMOD[5:3]
	localparam logic [2:0] cmBank4 = 3'd0;
	localparam logic [2:0] cmRgb16 = 3'd5;

	localparam clip_t sysClipReset = '{x1: 10'd0, y1: 9'd0, x2: 10'd319, y2: 9'd255};

	localparam int reqFifoDepth = 4;

endpackage

/* source/vramArbiter.sv */
`timescale 1ns/1ps

module vramArbiter import vdpPkg::*; (
	input  logic      CLK,
	input  logic      RST_N,

	input  logic      cmdReqValid,
	input  vramAddr_t cmdReqAddr,
	output logic      cmdReqReady,
	output logic      cmdRspValid,
	output word_t     cmdRspData,

	input  logic      patReqValid,
	input  vramAddr_t patReqAddr,
	output logic      patReqReady,
	output logic      patRspValid,
	output word_t     patRspData,

	output logic      vramReqValid,
	output vramAddr_t vramReqAddr,
	input  logic      vramReqReady,
	input  logic      vramRspValid,
	input  word_t     vramRspData
);

	typedef enum logic {reqCmd, reqPat} requester_t;

	requester_t orderMem [reqFifoDepth];
	logic [$clog2(reqFifoDepth)-1:0] wrPtr;
	logic [$clog2(reqFifoDepth)-1:0] rdPtr;
	logic [$clog2(reqFifoDepth):0] count;
	logic full;
	logic push;
	logic pop;
	requester_t head;

	assign full = count == reqFifoDepth;

	// Command fetch wins over pattern fetch
	assign vramReqValid = !full && (cmdReqValid || patReqValid);
	assign vramReqAddr = cmdReqValid ? cmdReqAddr : patReqAddr;
	assign cmdReqReady = !full && vramReqReady;
	assign patReqReady = !full && vramReqReady && !cmdReqValid;

	assign push = vramReqValid && vramReqReady;
	assign pop = vramRspValid;
	assign head = orderMem[rdPtr];

	// Responses come back in request order
	assign cmdRspValid = vramRspValid && head == reqCmd;
	assign patRspValid = vramRspValid && head == reqPat;
	assign cmdRspData = vramRspData;
	assign patRspData = vramRspData;

	always_ff @(posedge CLK) begin
		if (push) begin
			orderMem[wrPtr] <= cmdReqValid ? reqCmd : reqPat;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) wrPtr <= wrPtr + 1'b1;
			if (pop) rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// Memory must not answer a read that was never issued
	rspNeedsOwner: assert property (@(posedge CLK) disable iff (!RST_N)
		vramRspValid |-> count != 0);

	// A push must land in a free slot
	noPushWhenFull: assert property (@(posedge CLK) disable iff (!RST_N)
		push |-> count == '0 || wrPtr != rdPtr);

endmodule

/* source/cmdSequencer.sv */
`timescale 1ns/1ps

module cmdSequencer import vdpPkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       start,

	output logic       cmdReqValid,
	output vramAddr_t  cmdReqAddr,
	input  logic       cmdReqReady,
	input  logic       cmdRspValid,
	input  word_t      cmdRspData,

	output logic       sprValid,
	output spriteCmd_t sprJob,
	input  logic       sprReady,
	input  logic       sprDone,

	output logic       IRQ_N,
	output logic       busy
);

	typedef enum logic [2:0] {seqIdle, seqFetch, seqExec, seqDraw, seqNext} seqState_t;

	seqState_t state;
	vramAddr_t cmdAddr;
	vramAddr_t retAddr;
	vramAddr_t nextAddr;
	logic [3:0] issueCnt;
	logic [3:0] rspCnt;
	logic endFlag;
	clip_t sysClip;
	clip_t userClip;
	point_t localOrg;
	word_t cmdTbl [cmdFetchWords];
	word_t ctrl;
	word_t pmod;
	word_t xa;
	word_t ya;
	logic modeOk;

	assign ctrl = cmdTbl[ctrlOfs];
	assign pmod = cmdTbl[pmodOfs];
	assign xa = cmdTbl[xaOfs];
	assign ya = cmdTbl[yaOfs];
	assign modeOk = pmod[5:3] == cmBank4 || pmod[5:3] == cmRgb16;
	assign nextAddr = cmdAddr + vramAddr_t'(cmdWords);

	// Table reads go out back to back
	assign cmdReqValid = state == seqFetch && issueCnt < cmdFetchWords;
	assign cmdReqAddr = cmdAddr + vramAddr_t'(issueCnt);

	assign IRQ_N = !endFlag;
	assign busy = state != seqIdle;

	always_ff @(posedge CLK) begin
		if (cmdRspValid) begin
			cmdTbl[rspCnt] <= cmdRspData;
		end
	end

	always_comb begin
		sprJob.srcAddr = {cmdTbl[srcaOfs], 2'b00};
		sprJob.width = {cmdTbl[sizeOfs][13:8], 3'b000};
		sprJob.height = cmdTbl[sizeOfs][7:0];
		sprJob.colorMode = pmod[5:3];
		sprJob.colorBank = cmdTbl[colrOfs];
		sprJob.spd = pmod[6];
		sprJob.userClipEn = pmod[10];
		sprJob.origin.x = localOrg.x + coord_t'(xa[10:0]);
		sprJob.origin.y = localOrg.y + coord_t'(ya[10:0]);
		sprJob.sysClip = sysClip;
		sprJob.userClip = userClip;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= seqIdle;
			cmdAddr <= '0;
			retAddr <= '0;
			issueCnt <= '0;
			rspCnt <= '0;
			sprValid <= 1'b0;
			endFlag <= 1'b0;
			sysClip <= sysClipReset;
			userClip <= '0;
			localOrg <= '0;
		end else if (start) begin
			// List always restarts at word 0
			state <= seqFetch;
			cmdAddr <= '0;
			issueCnt <= '0;
			rspCnt <= '0;
			sprValid <= 1'b0;
			endFlag <= 1'b0;
		end else begin
			case (state)
				seqFetch: begin
					if (cmdReqValid && cmdReqReady) issueCnt <= issueCnt + 4'd1;
					if (cmdRspValid) begin
						rspCnt <= rspCnt + 4'd1;
						if (rspCnt == 4'(cmdFetchWords - 1)) state <= seqExec;
					end
				end
				seqExec: begin
					if (ctrl[15]) begin
						// END
						endFlag <= 1'b1;
						state <= seqIdle;
					end else begin
						state <= seqNext;
						// JP[2] skips execution only
						if (!ctrl[14]) begin
							case (ctrl[3:0])
								cmdNormal: begin
									if (modeOk) begin
										sprValid <= 1'b1;
										state <= seqDraw;
									end
								end
								cmdUserClip: begin
									userClip.x1 <= xa[9:0];
									userClip.y1 <= ya[8:0];
									userClip.x2 <= cmdTbl[xcOfs][9:0];
									userClip.y2 <= cmdTbl[ycOfs][8:0];
								end
								cmdSysClip: begin
									sysClip <= '{x1: 10'd0, y1: 9'd0,
										x2: cmdTbl[xcOfs][9:0], y2: cmdTbl[ycOfs][8:0]};
								end
								cmdLocal: begin
									localOrg.x <= xa[10:0];
									localOrg.y <= ya[10:0];
								end
								default: ;
							endcase
						end
					end
				end
				seqDraw: begin
					if (sprReady) sprValid <= 1'b0;
					if (sprDone) state <= seqNext;
				end
				seqNext: begin
					// JP[1:0] selects next, jump, call or return
					case (ctrl[13:12])
						2'b00: cmdAddr <= nextAddr;
						2'b01: cmdAddr <= {cmdTbl[linkOfs], 2'b00};
						2'b10: begin
							cmdAddr <= {cmdTbl[linkOfs], 2'b00};
							retAddr <= nextAddr;
						end
						default: cmdAddr <= retAddr;
					endcase
					issueCnt <= '0;
					rspCnt <= '0;
					state <= seqFetch;
				end
				default: ;
			endcase
		end
	end

	// Responses never outrun the reads issued for this table
	fetchCountBound: assert property (@(posedge CLK) disable iff (!RST_N)
		issueCnt <= cmdFetchWords && rspCnt <= issueCnt);

	// Arbiter must only route table words to us while fetching
	rspOnlyInFetch: assert property (@(posedge CLK) disable iff (!RST_N)
		cmdRspValid |-> state == seqFetch);

endmodule

/* source/spriteDraw.sv */
`timescale 1ns/1ps

module spriteDraw import vdpPkg::*; (
	input  logic       CLK,
	input  logic       RST_N,

	input  logic       sprValid,
	input  spriteCmd_t sprJob,
	output logic       sprReady,
	output logic       sprDone,

	output logic       patReqValid,
	output vramAddr_t  patReqAddr,
	input  logic       patReqReady,
	input  logic       patRspValid,
	input  word_t      patRspData,

	output logic       fbValid,
	output fbWrite_t   fbData,
	input  logic       fbReady
);

	typedef enum logic [2:0] {drIdle, drFetch, drWait, drPixel, drDone} drawState_t;

	drawState_t state;
	spriteCmd_t job;
	logic [8:0] px;
	logic [7:0] py;
	vramAddr_t rowAddr;
	vramAddr_t stride;
	word_t patWord;
	logic isRgb;
	logic [3:0] nibble;
	word_t color;
	logic transparent;
	coord_t drawX;
	coord_t drawY;
	logic sysIn;
	logic userIn;
	logic writeEn;
	logic step;
	logic lastX;
	logic lastY;

	assign isRgb = job.colorMode == cmRgb16;
	assign stride = isRgb ? vramAddr_t'(job.width) : vramAddr_t'(job.width[8:2]);

	assign sprReady = state == drIdle;
	assign sprDone = state == drDone;
	assign patReqValid = state == drFetch;
	assign patReqAddr = rowAddr + (isRgb ? vramAddr_t'(px) : vramAddr_t'(px[8:2]));

	// Bank mode reads nibbles from the MSB end
	always_comb begin
		case (px[1:0])
			2'd0: nibble = patWord[15:12];
			2'd1: nibble = patWord[11:8];
			2'd2: nibble = patWord[7:4];
			default: nibble = patWord[3:0];
		endcase
		color = isRgb ? patWord : {job.colorBank[15:4], nibble};
		transparent = isRgb ? patWord == '0 : nibble == '0;
	end

	assign drawX = job.origin.x + coord_t'({2'b00, px});
	assign drawY = job.origin.y + coord_t'({3'b000, py});

	assign sysIn = !drawX[10] && !drawY[10] && drawX[9:0] <= job.sysClip.x2
		&& drawY[9:0] <= {1'b0, job.sysClip.y2};
	assign userIn = drawX[9:0] >= job.userClip.x1 && drawX[9:0] <= job.userClip.x2
		&& drawY[9:0] >= {1'b0, job.userClip.y1} && drawY[9:0] <= {1'b0, job.userClip.y2};
	assign writeEn = state == drPixel && (!transparent || job.spd) && sysIn
		&& (userIn || !job.userClipEn);

	assign fbValid = writeEn;
	assign fbData = '{addr: {drawY[7:0], drawX[8:0]}, data: color};

	// Hidden pixels move on at once
	assign step = !writeEn || fbReady;
	assign lastX = px == job.width - 9'd1;
	assign lastY = py == job.height - 8'd1;

	always_ff @(posedge CLK) begin
		if (state == drIdle && sprValid) begin
			job <= sprJob;
			rowAddr <= sprJob.srcAddr;
		end else if (state == drPixel && step && lastX && !lastY) begin
			rowAddr <= rowAddr + stride;
		end
		if (state == drWait && patRspValid) begin
			patWord <= patRspData;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= drIdle;
			px <= '0;
			py <= '0;
		end else begin
			case (state)
				drIdle: begin
					if (sprValid) begin
						px <= '0;
						py <= '0;
						// Empty sprite
						if (sprJob.width == '0 || sprJob.height == '0) state <= drDone;
						else state <= drFetch;
					end
				end
				drFetch: if (patReqReady) state <= drWait;
				drWait: if (patRspValid) state <= drPixel;
				drPixel: begin
					if (step) begin
						if (lastX) begin
							px <= '0;
							if (lastY) begin
								state <= drDone;
							end else begin
								py <= py + 8'd1;
								state <= drFetch;
							end
						end else begin
							px <= px + 9'd1;
							// New pattern word needed
							if (isRgb || px[1:0] == 2'd3) state <= drFetch;
						end
					end
				end
				default: state <= drIdle;
			endcase
		end
	end

	fbHoldStable: assert property (@(posedge CLK) disable iff (!RST_N)
		fbValid && !fbReady |=> fbValid && $stable(fbData));

endmodule

/* source/vdpTop.sv */
`timescale 1ns/1ps

module vdpTop import vdpPkg::*; (
	input  logic      CLK,
	input  logic      RST_N,
	input  logic      start,

	output logic      vramReqValid,
	output vramAddr_t vramReqAddr,
	input  logic      vramReqReady,
	input  logic      vramRspValid,
	input  word_t     vramRspData,

	output logic      fbValid,
	output fbWrite_t  fbData,
	input  logic      fbReady,

	output logic      IRQ_N,
	output logic      busy
);

	// Command fetch path
	logic cmdReqValid;
	vramAddr_t cmdReqAddr;
	logic cmdReqReady;
	logic cmdRspValid;
	word_t cmdRspData;

	// Pattern fetch path
	logic patReqValid;
	vramAddr_t patReqAddr;
	logic patReqReady;
	logic patRspValid;
	word_t patRspData;

	// Sprite job handoff
	logic sprValid;
	spriteCmd_t sprJob;
	logic sprReady;
	logic sprDone;

	vramArbiter i_arbiter (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.cmdReqValid  (cmdReqValid),
		.cmdReqAddr   (cmdReqAddr),
		.cmdReqReady  (cmdReqReady),
		.cmdRspValid  (cmdRspValid),
		.cmdRspData   (cmdRspData),
		.patReqValid  (patReqValid),
		.patReqAddr   (patReqAddr),
		.patReqReady  (patReqReady),
		.patRspValid  (patRspValid),
		.patRspData   (patRspData),
		.vramReqValid (vramReqValid),
		.vramReqAddr  (vramReqAddr),
		.vramReqReady (vramReqReady),
		.vramRspValid (vramRspValid),
		.vramRspData  (vramRspData)
	);

	cmdSequencer i_cmdSeq (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.start       (start),
		.cmdReqValid (cmdReqValid),
		.cmdReqAddr  (cmdReqAddr),
		.cmdReqReady (cmdReqReady),
		.cmdRspValid (cmdRspValid),
		.cmdRspData  (cmdRspData),
		.sprValid    (sprValid),
		.sprJob      (sprJob),
		.sprReady    (sprReady),
		.sprDone     (sprDone),
		.IRQ_N       (IRQ_N),
		.busy        (busy)
	);

	spriteDraw i_draw (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.sprValid    (sprValid),
		.sprJob      (sprJob),
		.sprReady    (sprReady),
		.sprDone     (sprDone),
		.patReqValid (patReqValid),
		.patReqAddr  (patReqAddr),
		.patReqReady (patReqReady),
		.patRspValid (patRspValid),
		.patRspData  (patRspData),
		.fbValid     (fbValid),
		.fbData      (fbData),
		.fbReady     (fbReady)
	);

endmodule

/* tests/vramModel.sv */
`timescale 1ns/1ps

module vramModel import vdpPkg::*; (
	input  logic      CLK,
	input  logic      RST_N,
	input  logic      reqValid,
	input  vramAddr_t reqAddr,
	output logic      reqReady,
	output logic      rspValid,
	output word_t     rspData
);

	// Loaded by the testbench through the hierarchy
	word_t mem [2**18];

	vramAddr_t addrQ [$];
	int dueQ [$];
	int cycle;
	int seed;

	assign reqReady = 1'b1;

	initial begin
		seed = 32'h399e363a;
		rspValid = 1'b0;
		rspData = '0;
		cycle = 0;
	end

	// Accept every read, each with 1 to 4 cycles of latency
	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			addrQ.delete();
			dueQ.delete();
			cycle = 0;
		end else begin
			cycle = cycle + 1;
			if (reqValid) begin
				addrQ.push_back(reqAddr);
				dueQ.push_back(cycle + ($random(seed) & 3));
			end
		end
	end

	// Answers go out in request order, head only
	always @(negedge CLK) begin
		rspValid = 1'b0;
		if (RST_N && addrQ.size() > 0 && dueQ[0] <= cycle) begin
			rspValid = 1'b1;
			rspData = mem[addrQ.pop_front()];
			void'(dueQ.pop_front());
		end
	end

endmodule

/* tests/tbVdp.sv */
`timescale 1ns/1ps

module tbVdp import vdpPkg::*; ();

	logic CLK;
	logic RST_N;
	logic start;
	logic vramReqValid;
	vramAddr_t vramReqAddr;
	logic vramReqReady;
	logic vramRspValid;
	word_t vramRspData;
	logic fbValid;
	fbWrite_t fbData;
	logic fbReady;
	logic IRQ_N;
	logic busy;

	// Test data, flat queues with per-test bounds
	vramAddr_t mAddrQ [$];
	word_t mDataQ [$];
	fbAddr_t eAddrQ [$];
	word_t eDataQ [$];
	int mBegin [$];
	int mEnd [$];
	int eBegin [$];
	int eEnd [$];

	int expIdx;
	int expEnd;
	int seed;
	int watchLimit;
	logic loaded;

	vdpTop i_dut (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.start        (start),
		.vramReqValid (vramReqValid),
		.vramReqAddr  (vramReqAddr),
		.vramReqReady (vramReqReady),
		.vramRspValid (vramRspValid),
		.vramRspData  (vramRspData),
		.fbValid      (fbValid),
		.fbData       (fbData),
		.fbReady      (fbReady),
		.IRQ_N        (IRQ_N),
		.busy         (busy)
	);

	vramModel i_vram (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.reqValid (vramReqValid),
		.reqAddr  (vramReqAddr),
		.reqReady (vramReqReady),
		.rspValid (vramRspValid),
		.rspData  (vramRspData)
	);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	task automatic failRun(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic readTestData();
		int fd;
		string line;
		byte tag;
		logic [31:0] a;
		logic [31:0] d;
		int n;
		fd = $fopen("tests/vdp_testdata.txt", "r");
		if (fd == 0) failRun("Cannot open tests/vdp_testdata.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() > 1 && line.substr(0, 0) != "#") begin
				n = $sscanf(line, "%c %h %h", tag, a, d);
				if (tag == "T") begin
					mBegin.push_back(mAddrQ.size());
					eBegin.push_back(eAddrQ.size());
				end else if (tag == "M") begin
					mAddrQ.push_back(a[17:0]);
					mDataQ.push_back(d[15:0]);
				end else if (tag == "E") begin
					eAddrQ.push_back(a[16:0]);
					eDataQ.push_back(d[15:0]);
				end else if (tag == "X") begin
					mEnd.push_back(mAddrQ.size());
					eEnd.push_back(eAddrQ.size());
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic runTest(input int t);
		@(negedge CLK);
		for (int i = 0; i < 2**18; i++) i_vram.mem[i] = '0;
		for (int i = mBegin[t]; i < mEnd[t]; i++) i_vram.mem[mAddrQ[i]] = mDataQ[i];
		expIdx = eBegin[t];
		expEnd = eEnd[t];
		start = 1'b1;
		@(negedge CLK);
		start = 1'b0;
		// Flag cleared one cycle after start
		assert (IRQ_N === 1'b1)
			else failRun($sformatf("ERR %0t IRQ_N expected 1 actual %b", $time, IRQ_N));
		assert (busy === 1'b1)
			else failRun($sformatf("ERR %0t busy expected 1 actual %b", $time, busy));
		do @(negedge CLK); while (IRQ_N !== 1'b0);
		assert (busy === 1'b0)
			else failRun($sformatf("ERR %0t busy expected 0 actual %b", $time, busy));
		assert (expIdx == expEnd)
			else failRun($sformatf("Test %0d ended with %0d expected writes missing",
				t + 1, expEnd - expIdx));
	endtask

	// Random back-pressure on the frame buffer
	always @(negedge CLK) begin
		fbReady = ($random(seed) & 3) != 0;
	end

	always @(posedge CLK) begin
		if (RST_N === 1'b1 && fbValid && fbReady) begin
			assert (expIdx < expEnd)
				else failRun($sformatf("Unexpected frame-buffer write at %0t", $time));
			assert (fbData.addr == eAddrQ[expIdx])
				else failRun($sformatf("ERR %0t fbData.addr expected %05h actual %05h",
					$time, eAddrQ[expIdx], fbData.addr));
			assert (fbData.data == eDataQ[expIdx])
				else failRun($sformatf("ERR %0t fbData.data expected %04h actual %04h",
					$time, eDataQ[expIdx], fbData.data));
			expIdx = expIdx + 1;
		end
	end

	initial begin
		wait (loaded === 1'b1);
		#(watchLimit * 40);
		failRun("Timeout, the tests did not finish in time");
	end

	initial begin
		RST_N = 1'b0;
		start = 1'b0;
		fbReady = 1'b0;
		seed = 32'h399e363a;
		expIdx = 0;
		expEnd = 0;
		loaded = 1'b0;
		readTestData();
		watchLimit = (mAddrQ.size() + eAddrQ.size()) * 200;
		loaded = 1'b1;
		repeat (3) @(negedge CLK);
		RST_N = 1'b1;
		// Quiet until the first start
		repeat (4) begin
			@(negedge CLK);
			assert (IRQ_N === 1'b1 && busy === 1'b0)
				else failRun($sformatf("ERR %0t IRQ_N/busy expected 1/0 actual %b/%b",
					$time, IRQ_N, busy));
			assert (vramReqValid === 1'b0 && fbValid === 1'b0)
				else failRun("VRAM request or frame-buffer write before start");
		end
		for (int t = 0; t < eEnd.size(); t++) runTest(t);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* tests/vdp_testdata.txt */
# T n opens test n, X closes it; M addr word loads VRAM (hex)
# E addr data is the next expected frame-buffer write (hex), in order
T 1
M 000 000A
M 006 0005
M 007 0003
M 012 0028
M 014 0100
M 015 0101
M 016 0002
M 017 0001
M 020 8000
M 400 1111
M 403 3333
M 407 7777
E 807 1111
E 80A 3333
E 80E 7777
X
T 2
M 000 000A
M 013 1230
M 014 0100
M 015 0101
M 022 0040
M 023 1230
M 024 0100
M 025 0101
M 027 0001
M 030 8000
M 400 1023
M 401 4500
E 000 1231
E 002 1232
E 003 1233
E 004 1234
E 005 1235
E 200 1231
E 201 1230
E 202 1232
E 203 1233
E 204 1234
E 205 1235
E 206 1230
E 207 1230
X
T 3
M 000 100A
M 001 0010
M 040 2000
M 041 0020
M 044 0100
M 045 0101
M 047 0001
M 050 8000
M 080 4000
M 084 0100
M 085 0101
M 090 0003
M 094 0100
M 095 0101
M 0A0 3000
M 0A4 0100
M 0A5 0101
M 0A7 0002
M 400 1000
M 401 0002
E 200 0001
E 207 0002
E 400 0001
E 407 0002
X
T 4
M 000 000A
M 010 0009
M 01A 0014
M 01B 00FF
M 020 0008
M 026 0002
M 02A 0004
M 02B 00FF
M 034 0100
M 035 0101
M 036 0010
M 037 0001
M 042 0400
M 044 0100
M 045 0101
M 047 0002
M 054 0100
M 055 0101
M 057 0003
M 060 8000
M 400 1204
M 401 0050
E 210 0001
E 211 0002
E 213 0004
E 403 0004
E 600 0001
E 601 0002
E 603 0004
E 606 0005
X

/* verilog.f */
source/vdpPkg.sv
source/vramArbiter.sv
source/cmdSequencer.sv
source/spriteDraw.sv
source/vdpTop.sv
tests/vramModel.sv
tests/tbVdp.sv

/* Bender.yml */
package:
  name: vdp

sources:
  - source/vdpPkg.sv
  - source/vramArbiter.sv
  - source/cmdSequencer.sv
  - source/spriteDraw.sv
  - source/vdpTop.sv
  - target: test
    files:
      - tests/vramModel.sv
      - tests/tbVdp.sv
